// ==== hdl/audio_mix_channel.sv ====
module audio_mix_channel (
	input  logic                        clk,
	input  logic                        resetd,

	input  logic [sys_pkg::AUDIO_W-1:0] i_sample,
	input  logic                        i_is_signed,
	input  logic [1:0]                  i_mix,
	input  logic [sys_pkg::ATT_W-1:0]   i_att,
	input  logic [sys_pkg::AUDIO_W-1:0] i_pre,

	output logic [sys_pkg::AUDIO_W-1:0] o_pre,
	output logic [sys_pkg::AUDIO_W-1:0] o_out
);

	localparam int AW = sys_pkg::AUDIO_W;

	////////////////////
	// Deglitch

	logic [AW-1:0] smp_d1;
	logic [AW-1:0] smp_d2;

	always_ff @(posedge clk) begin
		smp_d1 <= i_sample;
		smp_d2 <= smp_d1;
	end

	////////////////////
	// Mix datapath

	logic [AW-1:0]        smp_q;
	logic signed [AW:0]   a_q;
	logic signed [AW:0]   m_q;
	logic signed [AW:0]   pre_ext;
	logic signed [AW:0]   m_next;
	logic signed [AW:0]   m_shift;
	logic signed [AW:0]   att_val;
	logic [AW-1:0]        clamped;

	// Other channel's pre value with sign extension
	assign pre_ext = signed'({i_pre[AW-1], i_pre});

	always_comb begin
		case (i_mix)
			2'd0: m_next = a_q;
			2'd1: m_next = a_q - (a_q >>> 3) + (pre_ext >>> 2);
			2'd2: m_next = a_q - (a_q >>> 2) + (pre_ext >>> 1);
			default: m_next = (a_q >>> 1) + pre_ext;
		endcase
	end

	// Shift down by the low attenuation bits
	assign m_shift = m_q >>> i_att[sys_pkg::ATT_W-2:0];

	// Mute on the top bit
	assign att_val = i_att[sys_pkg::ATT_W-1] ? '0 : m_shift;

	// Saturate to the 16 bit signed range
	assign clamped = (att_val[AW] != att_val[AW-1]) ?
		{att_val[AW], {(AW-1){att_val[AW-1]}}} : att_val[AW-1:0];

	always_ff @(posedge clk) begin
		if (resetd) begin
			smp_q <= '0;
			a_q   <= '0;
			m_q   <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Take the sample only once it held for two cycles
			if (smp_d1 == smp_d2) begin
				smp_q <= smp_d2;
			end
			if (i_is_signed) begin
				a_q <= signed'({smp_q[AW-1], smp_q});
			end else begin
				a_q <= signed'({2'b00, smp_q[AW-1:1]});
			end
			m_q   <= m_next;
			o_pre <= a_q[AW:1];
			o_out <= clamped;
		end
	end

	////////////////////
	// Checks

	a_mute: assert property (
		@(posedge clk) disable iff (resetd)
		i_att[sys_pkg::ATT_W-1] [*3] |-> (o_out == '0)
	) else $error("output not silent with mute set");

endmodule

// ==== hdl/csync_gen.sv ====
module csync_gen #(
	parameter int LINE_CNT_W = 16
) (
	input  logic               clk,
	input  logic               resetd,

	input  sys_pkg::vid_sync_t i_sync,
	output logic               o_csync
);

	logic                  prev_hs;
	logic                  hs_rise;
	logic                  got_hs;
	logic                  got_line;
	logic                  cs_hs;
	logic                  cs_vs;
	logic [LINE_CNT_W-1:0] h_cnt;
	logic [LINE_CNT_W-1:0] hs_pend;
	logic [LINE_CNT_W-1:0] hs_len;
	logic [LINE_CNT_W-1:0] line_len;
	logic [LINE_CNT_W-1:0] pre_pos;

	assign hs_rise = i_sync.hs & ~prev_hs;

	// One hsync length before the end of the line
	assign pre_pos = line_len - hs_len;

	always_ff @(posedge clk) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			got_hs   <= 1'b0;
			got_line <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			hs_pend  <= '0;
			hs_len   <= '0;
			line_len <= '0;
		end else begin
			prev_hs <= i_sync.hs;

			// Line counter restarts on each hsync start
			if (hs_rise) begin
				h_cnt <= '0;
			end else if (h_cnt != '1) begin
				h_cnt <= h_cnt + 1'b1;
			end

			if (~i_sync.hs & prev_hs) begin
				hs_pend <= h_cnt;
				got_hs  <= 1'b1;
			end

			// Pulse and line length are taken over together
			if (hs_rise) begin
				line_len <= h_cnt;
				hs_len   <= hs_pend;
				got_line <= got_hs;
			end

			// During vsync the pulse moves ahead by one hsync length
			if (!i_sync.vs) begin
				cs_hs <= i_sync.hs;
			end else if (hs_rise) begin
				cs_hs <= 1'b0;
			end else if (got_line && h_cnt == pre_pos) begin
				cs_hs <= 1'b1;
			end

			cs_vs <= i_sync.vs;
		end
	end

	assign o_csync = cs_hs ^ cs_vs;

	a_line_vs_pulse: assert property (
		@(posedge clk) disable iff (resetd)
		got_line |-> (line_len >= hs_len)
	) else $error("line shorter than hsync pulse");

endmodule

// ==== hdl/host_cmd_decoder.sv ====
module host_cmd_decoder (
	input  logic                      clk,
	input  logic                      resetd,

	input  sys_pkg::host_io_t         i_host,
	input  sys_pkg::led_core_t        i_led_core,

	output logic                      o_ack,
	output sys_pkg::sys_cfg_t         o_cfg,
	output logic [sys_pkg::ATT_W-1:0] o_att,
	output logic [7:0]                o_led
);

	////////////////////
	// Strobe handshake

	logic strobe_q;
	logic ack_q;
	logic strobe_edge;

	// Two register stages, the second one is the acknowledge
	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_q <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			strobe_q <= i_host.strobe;
			ack_q    <= strobe_q;
		end
	end

	// Strobe seen high last cycle, not yet acknowledged
	assign strobe_edge = strobe_q & ~ack_q;
	assign o_ack       = ack_q;

	////////////////////
	// Command and registers

	logic                      has_cmd;
	sys_pkg::cmd_e             cmd_q;
	logic [sys_pkg::IO_W-1:0]  cfg_q;
	logic [7:0]                led_mask;
	logic [7:0]                led_state;
	logic [sys_pkg::ATT_W-1:0] att_q;

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd_q     <= sys_pkg::CMD_CFG;
			cfg_q     <= '0;
			led_mask  <= '0;
			led_state <= '0;
			att_q     <= '0;
		end else if (!i_host.sel) begin
			// Port deselected, next word is a command again
			has_cmd <= 1'b0;
		end else if (strobe_edge) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd_q   <= sys_pkg::cmd_e'(i_host.din[sys_pkg::CMD_W-1:0]);
			end else begin
				case (cmd_q)
					sys_pkg::CMD_CFG: begin
						cfg_q <= i_host.din;
					end
					sys_pkg::CMD_LED: begin
						{led_mask, led_state} <= i_host.din;
					end
					sys_pkg::CMD_VOL: begin
						att_q <= i_host.din[sys_pkg::ATT_W-1:0];
					end
					default: begin
						// Data of unknown commands is dropped
					end
				endcase
			end
		end
	end

	assign o_cfg.csync_en = cfg_q[3];
	assign o_cfg.cfg_word = cfg_q;
	assign o_att          = att_q;

	////////////////////
	// LED merge

	logic       led_pwr;
	logic [7:0] led_def;

	// Power LED steady on unless the core takes control of it
	assign led_pwr = i_led_core.power[1] ? i_led_core.power[0] : 1'b1;

	assign led_def = {
		3'b000,
		led_pwr,
		1'b0,
		i_led_core.disk[0],
		1'b0,
		i_led_core.user
	};

	// Host override per bit where the mask is set
	assign o_led = (led_mask & led_state) | (~led_mask & led_def);

	////////////////////
	// Checks

	a_ack_after_strobe: assert property (
		@(posedge clk) disable iff (resetd)
		$rose(o_ack) |-> $past(i_host.strobe, 2)
	) else $error("acknowledge rose without strobe two cycles before");

endmodule

// ==== hdl/sync_polarity_fix.sv ====
module sync_polarity_fix #(
	parameter int LINE_CNT_W = 16
) (
	input  logic clk,
	input  logic resetd,

	input  logic i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic                  invert;
	logic [LINE_CNT_W-1:0] cnt;
	logic [LINE_CNT_W-1:0] high_len;
	logic [LINE_CNT_W-1:0] low_len;

	// Pulses always come out active high
	assign o_sync = i_sync ^ invert;

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			invert   <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// A rising edge ends the low phase, a falling edge the high phase
			if (s1 & ~s2) begin
				low_len <= cnt;
			end
			if (~s1 & s2) begin
				high_len <= cnt;
			end

			if (s1 != s2) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end

			// Long high phase means the pulse is the low one
			invert <= (high_len > low_len);
		end
	end

endmodule

// ==== hdl/sys_core.sv ====
module sys_core #(
	parameter int LINE_CNT_W = 16
) (
	input  logic                        clk,
	input  logic                        resetd,

	input  sys_pkg::host_io_t           i_host,
	input  sys_pkg::audio_in_t          i_audio,
	input  sys_pkg::led_core_t          i_led_core,
	input  sys_pkg::vid_sync_t          i_sync,

	output logic                        o_ack,
	output logic [sys_pkg::AUDIO_W-1:0] o_audio_l,
	output logic [sys_pkg::AUDIO_W-1:0] o_audio_r,
	output logic [7:0]                  o_led,
	output sys_pkg::vid_sync_t          o_sync
);

	sys_pkg::sys_cfg_t         cfg;
	logic [sys_pkg::ATT_W-1:0] att;

	////////////////////
	// Host port

	host_cmd_decoder host_i (
		.clk        (clk),
		.resetd     (resetd),
		.i_host     (i_host),
		.i_led_core (i_led_core),
		.o_ack      (o_ack),
		.o_cfg      (cfg),
		.o_att      (att),
		.o_led      (o_led)
	);

	////////////////////
	// Audio

	// Each channel feeds its pre value to the other
	logic [sys_pkg::AUDIO_W-1:0] pre_l;
	logic [sys_pkg::AUDIO_W-1:0] pre_r;

	audio_mix_channel mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_sample    (i_audio.left),
		.i_is_signed (i_audio.is_signed),
		.i_mix       (i_audio.mix),
		.i_att       (att),
		.i_pre       (pre_r),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mix_channel mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_sample    (i_audio.right),
		.i_is_signed (i_audio.is_signed),
		.i_mix       (i_audio.mix),
		.i_att       (att),
		.i_pre       (pre_l),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

	////////////////////
	// Video sync

	sys_pkg::vid_sync_t sync_fix;
	logic               csync;

	sync_polarity_fix #(.LINE_CNT_W(LINE_CNT_W)) fix_h (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.hs),
		.o_sync (sync_fix.hs)
	);

	sync_polarity_fix #(.LINE_CNT_W(LINE_CNT_W)) fix_v (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.vs),
		.o_sync (sync_fix.vs)
	);

	csync_gen #(.LINE_CNT_W(LINE_CNT_W)) csync_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_sync  (sync_fix),
		.o_csync (csync)
	);

	// Composite sync replaces hs when selected
	assign o_sync = '{hs: (cfg.csync_en ? csync : sync_fix.hs), vs: sync_fix.vs};

endmodule

// ==== hdl/sys_pkg.sv ====
package sys_pkg;

	////////////////////
	// Widths

	// Host data word
	localparam int IO_W = 16;
	// Command code, low byte of the first word
	localparam int CMD_W = 8;
	localparam int AUDIO_W = 16;
	// Bit 4 mutes, bits 3..0 shift
	localparam int ATT_W = 5;

	////////////////////
	// Host commands

	typedef enum logic [CMD_W-1:0] {
		CMD_CFG = 8'h01,
		CMD_LED = 8'h25,
		CMD_VOL = 8'h26
	} cmd_e;

	////////////////////
	// Grouped signals

	typedef struct packed {
		logic            sel;
		logic            strobe;
		logic [IO_W-1:0] din;
	} host_io_t;

	typedef struct packed {
		logic [AUDIO_W-1:0] left;
		logic [AUDIO_W-1:0] right;
		logic               is_signed;
		// Stereo cross-feed amount
		logic [1:0]         mix;
	} audio_in_t;

	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} led_core_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} vid_sync_t;

	typedef struct packed {
		// Copy of bit 3 of cfg_word
		logic            csync_en;
		logic [IO_W-1:0] cfg_word;
	} sys_cfg_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sys_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sys_core -f sys_core.f \
	-o tb_sys_core > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sys_core > sim.log 2>&1
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" && exit 0
echo "Simulation ended without a result, see sim.log"
exit 1

// ==== sys_core.f ====
hdl/sys_pkg.sv
hdl/host_cmd_decoder.sv
hdl/audio_mix_channel.sv
hdl/sync_polarity_fix.sv
hdl/csync_gen.sv
hdl/sys_core.sv
tb/tb_sys_core.sv

// ==== tb/tb_sys_core.sv ====
module tb_sys_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ROWS = 18;
	localparam int MAX_CYCLES = N_ROWS * 64 + 2000;
	// Sync timing, active low pulses with a short low phase
	localparam int H_PER = 24;
	localparam int H_LOW = 4;
	localparam int V_LINES = 6;
	localparam int V_LOW = 2;
	localparam int V_PER = H_PER * V_LINES;

	typedef struct packed {
		logic [7:0]  cmd;
		logic [15:0] data;
		logic [15:0] left;
		logic [15:0] right;
		logic        is_signed;
		logic [1:0]  mix;
		logic [4:0]  led;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		logic [7:0]  exp_led;
	} row_t;

	logic               clk;
	logic               resetd;
	sys_pkg::host_io_t  host;
	sys_pkg::audio_in_t audio;
	sys_pkg::led_core_t led_core;
	sys_pkg::vid_sync_t sync_in;
	logic               ack;
	logic [15:0]        audio_l;
	logic [15:0]        audio_r;
	logic [7:0]         led;
	sys_pkg::vid_sync_t sync_out;

	row_t        rows [N_ROWS];
	logic [31:0] lcg_state = 32'h777f_3a7f;
	int          cycles = 0;
	int          errors = 0;

	sys_core #(.LINE_CNT_W(16)) dut_i (
		.clk        (clk),
		.resetd     (resetd),
		.i_host     (host),
		.i_audio    (audio),
		.i_led_core (led_core),
		.i_sync     (sync_in),
		.o_ack      (ack),
		.o_audio_l  (audio_l),
		.o_audio_r  (audio_r),
		.o_led      (led),
		.o_sync     (sync_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "simulation timeout");
		end
	end

	// Free running hsync and vsync source
	initial begin
		int h_pos;
		int v_line;
		h_pos = 0;
		v_line = 0;
		sync_in = '1;
		forever begin
			@(posedge clk);
			#2;
			sync_in.hs = (h_pos >= H_LOW);
			sync_in.vs = (v_line >= V_LOW);
			if (h_pos == H_PER - 1) begin
				h_pos = 0;
				v_line = (v_line == V_LINES - 1) ? 0 : v_line + 1;
			end else begin
				h_pos = h_pos + 1;
			end
		end
	end

	////////////////////
	// Reference model

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Signed sample as is, unsigned sample halved
	function automatic int audio_base(input logic [15:0] smp, input logic sgn);
		int a;
		if (sgn)
			a = int'($signed(smp));
		else
			a = int'({1'b0, smp[15:1]});
		return a;
	endfunction

	function automatic logic [15:0] audio_expect(input logic [15:0] smp, input logic [15:0] oth,
		input logic sgn, input logic [1:0] mix, input logic [4:0] att);
		int a;
		int pre;
		int m;
		a = audio_base(smp, sgn);
		pre = audio_base(oth, sgn) >>> 1;
		case (mix)
			2'd0: m = a;
			2'd1: m = a - (a >>> 3) + (pre >>> 2);
			2'd2: m = a - (a >>> 2) + (pre >>> 1);
			default: m = (a >>> 1) + pre;
		endcase
		if (att[4])
			m = 0;
		else
			m = m >>> att[3:0];
		if (m > 32767)
			m = 32767;
		if (m < -32768)
			m = -32768;
		return m[15:0];
	endfunction

	function automatic logic [7:0] led_expect(input logic [7:0] mask, input logic [7:0] state,
		input logic [4:0] core);
		sys_pkg::led_core_t c;
		logic [7:0]         def;
		c = core;
		def = 8'h00;
		def[0] = c.user;
		def[2] = c.disk[0];
		def[4] = c.power[1] ? c.power[0] : 1'b1;
		return (mask & state) | (~mask & def);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	////////////////////
	// Stimulus table

	task automatic set_row(input int idx, input logic [7:0] cmd, input logic [15:0] data,
		input logic rnd, input logic [15:0] left, input logic [15:0] right,
		input logic sgn, input logic [1:0] mix, input logic [4:0] core);
		row_t r;
		r = '0;
		r.cmd = cmd;
		r.data = data;
		r.is_signed = sgn;
		r.mix = mix;
		r.led = core;
		if (rnd) begin
			r.left = lcg_next();
			r.right = lcg_next();
		end else begin
			r.left = left;
			r.right = right;
		end
		rows[idx] = r;
	endtask

	task automatic build_table();
		// LED override masks over several core LED values
		set_row(0, 8'h25, 16'h0000, 1'b1, 0, 0, 1'b1, 2'd0, 5'b11111);
		set_row(1, 8'h25, 16'hff5a, 1'b1, 0, 0, 1'b0, 2'd0, 5'b01001);
		set_row(2, 8'h25, 16'h1400, 1'b1, 0, 0, 1'b1, 2'd1, 5'b11010);
		set_row(3, 8'h25, 16'h0f0f, 1'b1, 0, 0, 1'b0, 2'd2, 5'b00100);
		// Attenuation shifts and mute
		set_row(4, 8'h26, 16'h0000, 1'b1, 0, 0, 1'b1, 2'd3, 5'b10000);
		set_row(5, 8'h26, 16'h0001, 1'b1, 0, 0, 1'b0, 2'd1, 5'b10110);
		set_row(6, 8'h26, 16'h0003, 1'b1, 0, 0, 1'b1, 2'd2, 5'b00011);
		set_row(7, 8'h26, 16'h0010, 1'b1, 0, 0, 1'b1, 2'd3, 5'b11100);
		set_row(8, 8'h26, 16'h0011, 1'b1, 0, 0, 1'b0, 2'd2, 5'b01110);
		set_row(9, 8'h26, 16'hffe2, 1'b1, 0, 0, 1'b1, 2'd1, 5'b10101);
		// Unknown code, its data must not reach any register
		set_row(10, 8'h40, 16'h0010, 1'b1, 0, 0, 1'b0, 2'd3, 5'b00001);
		// Full scale samples
		set_row(11, 8'h26, 16'h0000, 1'b0, 16'h7fff, 16'h7fff, 1'b1, 2'd1, 5'b11000);
		set_row(12, 8'h26, 16'h0000, 1'b0, 16'h8000, 16'h8000, 1'b1, 2'd2, 5'b00110);
		set_row(13, 8'h26, 16'h0000, 1'b0, 16'h8000, 16'h7fff, 1'b1, 2'd3, 5'b10011);
		set_row(14, 8'h26, 16'h0000, 1'b0, 16'hffff, 16'hffff, 1'b0, 2'd0, 5'b01100);
		set_row(15, 8'h26, 16'h0000, 1'b0, 16'hffff, 16'h0001, 1'b0, 2'd3, 5'b11110);
		set_row(16, 8'h01, 16'h0000, 1'b1, 0, 0, 1'b0, 2'd2, 5'b00010);
		set_row(17, 8'h26, 16'h0004, 1'b1, 0, 0, 1'b1, 2'd1, 5'b10001);
	endtask

	task automatic fill_expect();
		logic [7:0] mask;
		logic [7:0] state;
		logic [4:0] att;
		mask = '0;
		state = '0;
		att = '0;
		for (int i = 0; i < N_ROWS; i++) begin
			case (rows[i].cmd)
				sys_pkg::CMD_LED: {mask, state} = rows[i].data;
				sys_pkg::CMD_VOL: att = rows[i].data[4:0];
				default: ;
			endcase
			rows[i].exp_l = audio_expect(rows[i].left, rows[i].right, rows[i].is_signed,
				rows[i].mix, att);
			rows[i].exp_r = audio_expect(rows[i].right, rows[i].left, rows[i].is_signed,
				rows[i].mix, att);
			rows[i].exp_led = led_expect(mask, state, rows[i].led);
		end
	endtask

	////////////////////
	// Host port

	task automatic wait_ack(input logic level);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < 10 && !seen; n++) begin
			@(negedge clk);
			seen = (ack === level);
		end
		if (!seen) begin
			if (level)
				$display("The acknowledge never came within 10 cycles at %0t", $time);
			else
				$display("The acknowledge never dropped within 10 cycles at %0t", $time);
			$display("SOME TESTS FAILED");
			$fatal(1, "host handshake stuck");
		end
	endtask

	task automatic host_word(input logic [15:0] word);
		@(posedge clk);
		#2;
		host.din = word;
		host.strobe = 1'b1;
		wait_ack(1'b1);
		@(posedge clk);
		#2;
		host.strobe = 1'b0;
		wait_ack(1'b0);
	endtask

	// Command word then one data word, sel dropped afterwards
	task automatic host_write(input logic [7:0] cmd, input logic [15:0] data);
		@(posedge clk);
		#2;
		host.sel = 1'b1;
		host_word({8'h00, cmd});
		host_word(data);
		@(posedge clk);
		#2;
		host.sel = 1'b0;
	endtask

	task automatic apply_row(input int i);
		host_write(rows[i].cmd, rows[i].data);
		@(posedge clk);
		#2;
		audio.left = rows[i].left;
		audio.right = rows[i].right;
		audio.is_signed = rows[i].is_signed;
		audio.mix = rows[i].mix;
		led_core = rows[i].led;
		repeat (16) @(posedge clk);
		@(negedge clk);
		check_val("o_ack", ack, 1'b0);
		check_val("o_led", led, rows[i].exp_led);
		check_val("o_audio_l", audio_l, rows[i].exp_l);
		check_val("o_audio_r", audio_r, rows[i].exp_r);
	endtask

	////////////////////
	// Sync checks

	task automatic sync_checks();
		logic prev_hs;
		logic prev_vs;
		host_write(sys_pkg::CMD_CFG, 16'h0000);
		// Both polarity detectors need two full periods
		repeat (3 * V_PER) @(posedge clk);
		for (int n = 0; n < V_PER; n++) begin
			@(negedge clk);
			check_val("o_sync.hs", sync_out.hs, !sync_in.hs);
			check_val("o_sync.vs", sync_out.vs, !sync_in.vs);
		end
		// Composite sync on the hs output
		host_write(sys_pkg::CMD_CFG, 16'h0008);
		@(negedge clk);
		prev_hs = !sync_in.hs;
		prev_vs = sync_in.vs;
		for (int n = 0; n < V_PER; n++) begin
			@(negedge clk);
			if (prev_vs && sync_in.vs)
				check_val("o_sync.hs", sync_out.hs, prev_hs);
			check_val("o_sync.vs", sync_out.vs, !sync_in.vs);
			prev_hs = !sync_in.hs;
			prev_vs = sync_in.vs;
		end
	endtask

	initial begin
		resetd = 1'b1;
		host = '0;
		audio = '0;
		led_core = 5'b1_00_01;
		build_table();
		fill_expect();
		repeat (5) @(posedge clk);
		#2;
		resetd = 1'b0;

		// Idle state after reset
		repeat (16) @(posedge clk);
		@(negedge clk);
		check_val("o_ack", ack, 1'b0);
		check_val("o_led", led, led_expect(8'h00, 8'h00, led_core));
		check_val("o_audio_l", audio_l, 16'h0000);
		check_val("o_audio_r", audio_r, 16'h0000);

		for (int i = 0; i < N_ROWS; i++)
			apply_row(i);
		sync_checks();

		if (errors == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule
